//--- verilog/clk_mon_pkg.sv
`default_nettype none

package clk_mon_pkg;

  ////////////////////////////////////////////////////////////
  // Sizes and timing
  ////////////////////////////////////////////////////////////

  localparam int NUM_MON       = 2;   // Measured clocks.
  localparam int WINDOW_BITS   = 10;  // Window is 2^WINDOW_BITS d_clk cycles.
  localparam int STALE_WINDOWS = 4;

  // A channel is lost after this many d_clk cycles without an update.
  localparam int STALE_CYCLES  = STALE_WINDOWS << WINDOW_BITS;
  localparam int STALE_BITS    = $clog2(STALE_CYCLES) + 1;

  typedef logic [31:0]            count_t;
  typedef logic [3:0]             addr_t;
  typedef logic [31:0]            data_t;
  typedef logic [WINDOW_BITS-1:0] window_t;
  typedef logic [STALE_BITS-1:0]  stale_t;

  ////////////////////////////////////////////////////////////
  // Register map
  ////////////////////////////////////////////////////////////

  localparam addr_t REG_COUNT0 = 4'd0;  // Read only.
  localparam addr_t REG_COUNT1 = 4'd1;  // Read only.
  localparam addr_t REG_MIN0   = 4'd2;
  localparam addr_t REG_MAX0   = 4'd3;
  localparam addr_t REG_MIN1   = 4'd4;
  localparam addr_t REG_MAX1   = 4'd5;

  // Bits [NUM_MON-1:0] are range alarms and the next NUM_MON bits are lost flags.
  localparam addr_t REG_STATUS = 4'd6;

  localparam count_t MIN_RESET = '0;
  localparam count_t MAX_RESET = '1;

  ////////////////////////////////////////////////////////////
  // Bus payloads
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic  write;
    addr_t addr;
    data_t wdata;
  } reg_req_t;

  typedef struct packed {
    data_t rdata;
    logic  err;
  } reg_rsp_t;

  typedef enum logic {
    ST_IDLE,
    ST_RESPOND
  } mon_state_e;

endpackage

`default_nettype wire

//--- verilog/toggle_sync.sv
`timescale 1ns/1ps
`default_nettype none

module toggle_sync (
  input  logic clk,
  input  logic toggle_in,
  output logic change
);

  // Three stage chain into the clk domain.
  logic sync_m1 = 1'b0;
  logic sync_m2 = 1'b0;
  logic sync_m3 = 1'b0;

  always_ff @(posedge clk) begin
    sync_m1 <= toggle_in;  // Metastable stage.
    sync_m2 <= sync_m1;
    sync_m3 <= sync_m2;
  end

  // One cycle pulse per edge of the incoming toggle.
  assign change = sync_m3 ^ sync_m2;

endmodule

`default_nettype wire

//--- verilog/clk_rate_counter.sv
`timescale 1ns/1ps
`default_nettype none

module clk_rate_counter (
  input  logic                d_clk,
  input  logic                d_rst,
  input  logic                mon_clk,
  output clk_mon_pkg::count_t count,
  output logic                count_update
);

  localparam int CNT_W = $bits(clk_mon_pkg::count_t);

  // Reference side.
  clk_mon_pkg::window_t win_cnt;
  logic                 win_toggle;
  logic                 ret_change;

  // Measured side.
  logic [CNT_W:0]       mon_cnt = '0;
  clk_mon_pkg::count_t  mon_hold = '0;
  logic                 ret_toggle = 1'b0;
  logic                 win_change;

  ////////////////////////////////////////////////////////////
  // d_clk domain
  ////////////////////////////////////////////////////////////

  // The window toggle flips once per 2^WINDOW_BITS cycles.
  always_ff @(posedge d_clk) begin
    if (d_rst) begin
      win_cnt    <= '0;
      win_toggle <= 1'b0;
    end else begin
      win_cnt <= win_cnt + 1'b1;
      if (win_cnt == '0) begin
        win_toggle <= ~win_toggle;
      end
    end
  end

  toggle_sync u_ret_sync (
    .clk       (d_clk),
    .toggle_in (ret_toggle),
    .change    (ret_change)
  );

  // The hold register is static by the time the return toggle arrives.
  always_ff @(posedge d_clk) begin
    if (d_rst) begin
      count        <= '0;
      count_update <= 1'b0;
    end else begin
      count_update <= ret_change;
      if (ret_change) begin
        count <= mon_hold;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // mon_clk domain
  ////////////////////////////////////////////////////////////

  toggle_sync u_win_sync (
    .clk       (mon_clk),
    .toggle_in (win_toggle),
    .change    (win_change)
  );

  always_ff @(posedge mon_clk) begin
    if (win_change) begin
      ret_toggle <= ~ret_toggle;
      mon_hold   <= mon_cnt[CNT_W] ? '1 : mon_cnt[CNT_W-1:0];
    end
  end

  // The window edge restarts the count at 1 since the edge cycle counts.
  always_ff @(posedge mon_clk) begin
    if (win_change) begin
      mon_cnt <= {{CNT_W{1'b0}}, 1'b1};
    end else if (!mon_cnt[CNT_W]) begin
      mon_cnt <= mon_cnt + 1'b1;
    end else begin
      mon_cnt <= '1;  // Saturated.
    end
  end

endmodule

`default_nettype wire

//--- verilog/clk_mon_regs.sv
`timescale 1ns/1ps
`default_nettype none

module clk_mon_regs (
  input  logic                                            d_clk,
  input  logic                                            d_rst,
  input  clk_mon_pkg::count_t [clk_mon_pkg::NUM_MON-1:0] count_in,
  input  logic [clk_mon_pkg::NUM_MON-1:0]                 count_update,
  input  clk_mon_pkg::reg_req_t                           req,
  input  logic                                            req_valid,
  output logic                                            req_ready,
  output clk_mon_pkg::reg_rsp_t                           rsp,
  output logic                                            rsp_valid,
  input  logic                                            rsp_ready,
  output logic                                            irq
);

  localparam int N = clk_mon_pkg::NUM_MON;

  clk_mon_pkg::mon_state_e          state;
  logic                             accept;
  logic                             wr_en;

  clk_mon_pkg::count_t [N-1:0]      count_q;
  clk_mon_pkg::count_t [N-1:0]      min_q;
  clk_mon_pkg::count_t [N-1:0]      max_q;
  clk_mon_pkg::stale_t [N-1:0]      stale_q;
  logic [N-1:0]                     stale_hit;
  logic [2*N-1:0]                   status_q;
  logic [2*N-1:0]                   status_set;
  logic [2*N-1:0]                   status_clr;

  clk_mon_pkg::data_t               rd_data;
  logic                             rd_err;
  logic                             wr_err;
  logic [N-1:0]                     min_we;
  logic [N-1:0]                     max_we;
  logic                             status_we;

  ////////////////////////////////////////////////////////////
  // Bus handshake
  ////////////////////////////////////////////////////////////

  assign req_ready = (state == clk_mon_pkg::ST_IDLE);
  assign rsp_valid = (state == clk_mon_pkg::ST_RESPOND);
  assign accept    = req_valid && req_ready;
  assign wr_en     = accept && req.write;

  always_ff @(posedge d_clk) begin
    if (d_rst) begin
      state <= clk_mon_pkg::ST_IDLE;
    end else begin
      case (state)
        clk_mon_pkg::ST_IDLE: begin
          if (req_valid) state <= clk_mon_pkg::ST_RESPOND;
        end
        clk_mon_pkg::ST_RESPOND: begin
          if (rsp_ready) state <= clk_mon_pkg::ST_IDLE;  // Held until taken.
        end
        default: state <= clk_mon_pkg::ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge d_clk) begin
    if (accept) begin
      rsp.rdata <= req.write ? '0 : rd_data;
      rsp.err   <= req.write ? wr_err : rd_err;
    end
  end

  // Address decode.
  always_comb begin
    rd_data   = '0;
    rd_err    = 1'b0;
    wr_err    = 1'b0;
    min_we    = '0;
    max_we    = '0;
    status_we = 1'b0;
    case (req.addr)
      clk_mon_pkg::REG_COUNT0: begin
        rd_data = count_q[0];
        wr_err  = 1'b1;
      end
      clk_mon_pkg::REG_COUNT1: begin
        rd_data = count_q[1];
        wr_err  = 1'b1;
      end
      clk_mon_pkg::REG_MIN0: begin
        rd_data   = min_q[0];
        min_we[0] = wr_en;
      end
      clk_mon_pkg::REG_MAX0: begin
        rd_data   = max_q[0];
        max_we[0] = wr_en;
      end
      clk_mon_pkg::REG_MIN1: begin
        rd_data   = min_q[1];
        min_we[1] = wr_en;
      end
      clk_mon_pkg::REG_MAX1: begin
        rd_data   = max_q[1];
        max_we[1] = wr_en;
      end
      clk_mon_pkg::REG_STATUS: begin
        rd_data   = clk_mon_pkg::data_t'(status_q);
        status_we = wr_en;
      end
      default: begin
        rd_err = 1'b1;
        wr_err = 1'b1;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Counts, thresholds and status
  ////////////////////////////////////////////////////////////

  always_comb begin
    status_set = '0;
    for (int i = 0; i < N; i++) begin
      stale_hit[i] = (stale_q[i] == clk_mon_pkg::STALE_CYCLES);
      if (count_update[i] && ((count_in[i] < min_q[i]) || (count_in[i] > max_q[i]))) begin
        status_set[i] = 1'b1;
      end
      status_set[N+i] = stale_hit[i];
    end
    status_clr = status_we ? req.wdata[2*N-1:0] : '0;  // Write 1 to clear.
  end

  always_ff @(posedge d_clk) begin
    if (d_rst) begin
      status_q <= '0;
      for (int i = 0; i < N; i++) begin
        count_q[i] <= '0;
        min_q[i]   <= clk_mon_pkg::MIN_RESET;
        max_q[i]   <= clk_mon_pkg::MAX_RESET;
        stale_q[i] <= '0;
      end
    end else begin
      status_q <= (status_q & ~status_clr) | status_set;  // New events win.
      for (int i = 0; i < N; i++) begin
        if (min_we[i]) min_q[i] <= req.wdata;
        if (max_we[i]) max_q[i] <= req.wdata;
        if (count_update[i]) begin
          count_q[i] <= count_in[i];
          stale_q[i] <= '0;
        end else if (stale_hit[i]) begin
          count_q[i] <= '0;  // Timer parks here until the clock returns.
        end else begin
          stale_q[i] <= stale_q[i] + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge d_clk) begin
    if (d_rst) begin
      irq <= 1'b0;
    end else begin
      irq <= |status_q;
    end
  end

endmodule

`default_nettype wire

//--- verilog/clk_mon_top.sv
`timescale 1ns/1ps
`default_nettype none

module clk_mon_top (
  input  logic                            d_clk,
  input  logic                            d_rst,
  input  logic [clk_mon_pkg::NUM_MON-1:0] mon_clk,
  input  clk_mon_pkg::reg_req_t           req,
  input  logic                            req_valid,
  output logic                            req_ready,
  output clk_mon_pkg::reg_rsp_t           rsp,
  output logic                            rsp_valid,
  input  logic                            rsp_ready,
  output logic                            irq
);

  clk_mon_pkg::count_t [clk_mon_pkg::NUM_MON-1:0] count;
  logic [clk_mon_pkg::NUM_MON-1:0]                count_update;

  ////////////////////////////////////////////////////////////
  // One rate counter per measured clock
  ////////////////////////////////////////////////////////////

  generate
    for (genvar i = 0; i < clk_mon_pkg::NUM_MON; i++) begin : g_mon
      clk_rate_counter u_counter (
        .d_clk        (d_clk),
        .d_rst        (d_rst),
        .mon_clk      (mon_clk[i]),
        .count        (count[i]),
        .count_update (count_update[i])
      );
    end
  endgenerate

  // Register block on d_clk.
  clk_mon_regs u_regs (
    .d_clk        (d_clk),
    .d_rst        (d_rst),
    .count_in     (count),
    .count_update (count_update),
    .req          (req),
    .req_valid    (req_valid),
    .req_ready    (req_ready),
    .rsp          (rsp),
    .rsp_valid    (rsp_valid),
    .rsp_ready    (rsp_ready),
    .irq          (irq)
  );

endmodule

`default_nettype wire

//--- tests/clk_mon_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module clk_mon_asserts (
  input logic                              d_clk,
  input logic                              d_rst,
  input logic                              req_ready,
  input clk_mon_pkg::reg_rsp_t             rsp,
  input logic                              rsp_valid,
  input logic                              rsp_ready,
  input logic                              irq,
  input logic [2*clk_mon_pkg::NUM_MON-1:0] status
);

  int unsigned fail_count = 0;

  // A stalled response keeps its payload.
  rsp_held: assert property (@(posedge d_clk) disable iff (d_rst)
      (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp)))
    else begin
      fail_count++;
      $error("Response changed while waiting for rsp_ready.");
    end

  one_in_flight: assert property (@(posedge d_clk) disable iff (d_rst)
      rsp_valid |-> !req_ready)
    else begin
      fail_count++;
      $error("req_ready high while a response is pending.");
    end

  irq_follows: assert property (@(posedge d_clk) disable iff (d_rst)
      irq == |$past(status))  // One cycle behind the status bits.
    else begin
      fail_count++;
      $error("irq does not match the registered status OR.");
    end

endmodule

`default_nettype wire

//--- tests/clk_mon_checker.sv
`timescale 1ns/1ps
`default_nettype none

module clk_mon_checker (
  input logic                  d_clk,
  input clk_mon_pkg::reg_rsp_t rsp,
  input logic                  rsp_valid,
  input logic                  rsp_ready,
  input logic                  irq
);

  // Expected responses in request order.
  string              name_q[$];
  clk_mon_pkg::data_t exp_q[$];
  clk_mon_pkg::data_t tol_q[$];
  logic               err_q[$];

  int unsigned checked    = 0;  // Responses taken so far.
  int unsigned pass_count = 0;
  int unsigned fail_count = 0;

  task automatic expect_rsp(input string name, input clk_mon_pkg::data_t exp,
                            input clk_mon_pkg::data_t tol, input logic err);
    name_q.push_back(name);
    exp_q.push_back(exp);
    tol_q.push_back(tol);
    err_q.push_back(err);
  endtask

  function automatic logic in_range(input clk_mon_pkg::data_t got,
                                    input clk_mon_pkg::data_t exp,
                                    input clk_mon_pkg::data_t tol);
    clk_mon_pkg::data_t diff;
    diff = (got > exp) ? got - exp : exp - got;
    return diff <= tol;
  endfunction

  task automatic check_irq(input string name, input logic exp);
    if (irq === exp) begin
      pass_count++;
      $display("PASS    %s", name);
    end else begin
      fail_count++;
      $display("FAILED at %0d ns: %s irq is %b, expected %b", $time, name, irq, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Response compare at each transfer
  ////////////////////////////////////////////////////////////

  always @(posedge d_clk) begin
    string              name;
    clk_mon_pkg::data_t exp;
    clk_mon_pkg::data_t tol;
    logic               err;
    if (rsp_valid && rsp_ready) begin
      checked++;
      if (name_q.size() == 0) begin
        fail_count++;
        $display("A response arrived at %0d ns with nothing expected", $time);
      end else begin
        name = name_q.pop_front();
        exp  = exp_q.pop_front();
        tol  = tol_q.pop_front();
        err  = err_q.pop_front();
        if (rsp.err === err && in_range(rsp.rdata, exp, tol) === 1'b1) begin
          pass_count++;
          $display("PASS    %s", name);
        end else begin
          fail_count++;
          $display("FAILED at %0d ns: %s got 0x%08h err %b, expected 0x%08h +/- %0d err %b",
                   $time, name, rsp.rdata, rsp.err, exp, tol, err);
        end
      end
    end
  end

  task automatic print_counts();
    $display("Checks: %0d passed, %0d failed, %0d responses missing",
             pass_count, fail_count, name_q.size());
  endtask

  function automatic int unsigned error_total();
    return fail_count + name_q.size();
  endfunction

endmodule

`default_nettype wire

//--- tests/tb_clk_mon.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_mon;

  typedef enum logic [2:0] {OP_READ, OP_WRITE, OP_WAIT, OP_STOP, OP_IRQ} op_e;

  typedef struct packed {
    op_e                op;
    clk_mon_pkg::addr_t addr;
    clk_mon_pkg::data_t wdata;  // Window count for OP_WAIT.
    clk_mon_pkg::data_t exp;
    clk_mon_pkg::data_t tol;
    logic               err;
  } row_t;

  logic                            d_clk    = 1'b0;
  logic                            mon_clk0 = 1'b0;
  logic                            mon_clk1 = 1'b0;
  logic                            mon1_run = 1'b1;
  logic                            d_rst;
  logic [clk_mon_pkg::NUM_MON-1:0] mon_clk;
  clk_mon_pkg::reg_req_t           req;
  logic                            req_valid;
  logic                            req_ready;
  clk_mon_pkg::reg_rsp_t           rsp;
  logic                            rsp_valid;
  logic                            rsp_ready;
  logic                            irq;

  row_t  stim_rows[$];
  string stim_names[$];
  logic  table_ready = 1'b0;

  always #50 d_clk = ~d_clk;        // 10 MHz reference.
  always #20 mon_clk0 = ~mon_clk0;  // 25 MHz.
  always #125 begin
    if (mon1_run) mon_clk1 = ~mon_clk1;  // 4 MHz until stopped.
  end
  assign mon_clk = {mon_clk1, mon_clk0};

  clk_mon_top dut (
    .d_clk     (d_clk),
    .d_rst     (d_rst),
    .mon_clk   (mon_clk),
    .req       (req),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .rsp       (rsp),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .irq       (irq)
  );

  clk_mon_checker u_checker (
    .d_clk     (d_clk),
    .rsp       (rsp),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .irq       (irq)
  );

  bind clk_mon_regs clk_mon_asserts u_asserts (
    .d_clk     (d_clk),
    .d_rst     (d_rst),
    .req_ready (req_ready),
    .rsp       (rsp),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .irq       (irq),
    .status    (status_q)
  );

  ////////////////////////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////////////////////////

  task automatic add_row(input string name, input op_e op, input clk_mon_pkg::addr_t addr,
                         input clk_mon_pkg::data_t wdata, input clk_mon_pkg::data_t exp,
                         input clk_mon_pkg::data_t tol, input logic err);
    row_t row;
    row = '{op, addr, wdata, exp, tol, err};
    stim_rows.push_back(row);
    stim_names.push_back(name);
  endtask

  task automatic load_table();
    add_row("rd_count0_reset", OP_READ,  clk_mon_pkg::REG_COUNT0, 0, 0, 0, 1'b0);
    add_row("rd_count1_reset", OP_READ,  clk_mon_pkg::REG_COUNT1, 0, 0, 0, 1'b0);
    add_row("rd_min0_reset",   OP_READ,  clk_mon_pkg::REG_MIN0, 0, clk_mon_pkg::MIN_RESET, 0, 1'b0);
    add_row("rd_max0_reset",   OP_READ,  clk_mon_pkg::REG_MAX0, 0, clk_mon_pkg::MAX_RESET, 0, 1'b0);
    add_row("rd_min1_reset",   OP_READ,  clk_mon_pkg::REG_MIN1, 0, clk_mon_pkg::MIN_RESET, 0, 1'b0);
    add_row("rd_max1_reset",   OP_READ,  clk_mon_pkg::REG_MAX1, 0, clk_mon_pkg::MAX_RESET, 0, 1'b0);
    add_row("rd_status_reset", OP_READ,  clk_mon_pkg::REG_STATUS, 0, 0, 0, 1'b0);
    add_row("irq_reset",       OP_IRQ,   4'd0, 0, 0, 0, 1'b0);
    add_row("wait_settle",     OP_WAIT,  4'd0, 3, 0, 0, 1'b0);
    add_row("rd_count0_rate",  OP_READ,  clk_mon_pkg::REG_COUNT0, 0, 2560, 2, 1'b0);
    add_row("rd_count1_rate",  OP_READ,  clk_mon_pkg::REG_COUNT1, 0, 410, 2, 1'b0);
    add_row("wr_min1_high",    OP_WRITE, clk_mon_pkg::REG_MIN1, 500, 0, 0, 1'b0);
    add_row("wait_alarm",      OP_WAIT,  4'd0, 2, 0, 0, 1'b0);
    add_row("rd_status_alarm", OP_READ,  clk_mon_pkg::REG_STATUS, 0, 32'h2, 0, 1'b0);
    add_row("irq_alarm",       OP_IRQ,   4'd0, 0, 1, 0, 1'b0);
    add_row("wr_min1_low",     OP_WRITE, clk_mon_pkg::REG_MIN1, 0, 0, 0, 1'b0);
    add_row("wr_status_clear", OP_WRITE, clk_mon_pkg::REG_STATUS, 32'h2, 0, 0, 1'b0);
    add_row("wait_clear",      OP_WAIT,  4'd0, 2, 0, 0, 1'b0);
    add_row("rd_status_clear", OP_READ,  clk_mon_pkg::REG_STATUS, 0, 0, 0, 1'b0);
    add_row("irq_clear",       OP_IRQ,   4'd0, 0, 0, 0, 1'b0);
    add_row("stop_mon1",       OP_STOP,  4'd0, 0, 0, 0, 1'b0);
    add_row("wait_loss",       OP_WAIT,  4'd0, clk_mon_pkg::STALE_WINDOWS + 2, 0, 0, 1'b0);
    add_row("rd_status_loss",  OP_READ,  clk_mon_pkg::REG_STATUS, 0, 32'h8, 0, 1'b0);
    add_row("rd_count1_loss",  OP_READ,  clk_mon_pkg::REG_COUNT1, 0, 0, 0, 1'b0);
    add_row("rd_count0_loss",  OP_READ,  clk_mon_pkg::REG_COUNT0, 0, 2560, 2, 1'b0);
    add_row("irq_loss",        OP_IRQ,   4'd0, 0, 1, 0, 1'b0);
    add_row("wr_count0_err",   OP_WRITE, clk_mon_pkg::REG_COUNT0, 32'h55, 0, 0, 1'b1);
    add_row("rd_bad_addr_err", OP_READ,  4'd9, 0, 0, 0, 1'b1);
  endtask

  // Runs from a falling edge to the falling edge after the response is taken.
  task automatic bus_access(input string name, input row_t row);
    int unsigned target;
    target = u_checker.checked + 1;
    u_checker.expect_rsp(name, row.exp, row.tol, row.err);
    req.write = (row.op == OP_WRITE);
    req.addr  = row.addr;
    req.wdata = row.wdata;
    req_valid = 1'b1;
    while (!req_ready) @(negedge d_clk);
    @(negedge d_clk);  // Accepted on the rising edge just passed.
    req_valid = 1'b0;
    while (u_checker.checked < target) @(negedge d_clk);
  endtask

  task automatic run_row(input string name, input row_t row);
    case (row.op)
      OP_READ, OP_WRITE: bus_access(name, row);
      OP_WAIT: repeat (row.wdata << clk_mon_pkg::WINDOW_BITS) @(negedge d_clk);
      OP_STOP: mon1_run = 1'b0;
      default: u_checker.check_irq(name, row.exp[0]);
    endcase
  endtask

  ////////////////////////////////////////////////////////////
  // Run control
  ////////////////////////////////////////////////////////////

  initial begin
    rsp_ready = 1'b1;
    void'($urandom(32'hb17a1b2e));
    forever begin
      @(negedge d_clk);
      rsp_ready = (($urandom % 4) != 0);  // Stall about one cycle in four.
    end
  end

  initial begin
    int unsigned limit_ns;
    wait (table_ready);
    limit_ns = stim_rows.size() * (clk_mon_pkg::STALE_WINDOWS + 2)
             * (2 ** clk_mon_pkg::WINDOW_BITS) * 100;
    #(limit_ns);
    $display("Timeout: the tests did not finish within %0d ns", limit_ns);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    d_rst     = 1'b1;
    req       = '0;
    req_valid = 1'b0;
    load_table();
    table_ready = 1'b1;
    repeat (8) @(negedge d_clk);
    d_rst = 1'b0;
    foreach (stim_rows[i]) begin
      run_row(stim_names[i], stim_rows[i]);
    end
    u_checker.print_counts();
    if (u_checker.error_total() == 0 && dut.u_regs.u_asserts.fail_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
verilog/clk_mon_pkg.sv
verilog/toggle_sync.sv
verilog/clk_rate_counter.sv
verilog/clk_mon_regs.sv
verilog/clk_mon_top.sv
tests/clk_mon_asserts.sv
tests/clk_mon_checker.sv
tests/tb_clk_mon.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the clock monitor testbench with Verilator and runs it.
set -u
cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 --timescale 1ns/1ps \
  --top-module tb_clk_mon -Mdir "$OBJ_DIR" -f filelist.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ_DIR/Vtb_clk_mon" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q "Simulation completed successfully" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
